// ==== agc_pkg.sv ====
`default_nettype none

package agc_pkg;

    ////////////////////////////////////////////////////////////////////
    // Stream and register widths
    ////////////////////////////////////////////////////////////////////
    localparam int NSAMP = 4;                   // Samples per clock

    typedef logic signed [11:0] sample_t;       // Raw input sample
    typedef logic signed [4:0]  code_t;         // Saturated output code
    typedef logic        [16:0] scale_t;        // Gain, 12 fraction bits
    typedef logic signed [15:0] offset_t;       // Offset in input units
    typedef logic        [23:0] sqsum_t;        // Window sum of squared codes
    typedef logic        [9:0]  count_t;        // Window sign counts

    localparam code_t CODE_MAX = 5'sd15;
    localparam code_t CODE_MIN = -5'sd16;

    localparam int SCALE_FRAC_BITS = 12;
    localparam int WINDOW_BITS     = 6;         // 64 clocks, 256 codes

    ////////////////////////////////////////////////////////////////////
    // Loop constants
    ////////////////////////////////////////////////////////////////////
    localparam scale_t  START_SCALE  = 17'd1500;
    localparam offset_t START_OFFSET = 16'sd0;
    localparam scale_t  SCALE_DELTA  = 17'd30;
    localparam offset_t OFFSET_DELTA = 16'sd25;
    localparam scale_t  SCALE_FLOOR  = 17'd300;
    localparam scale_t  SCALE_CEIL   = 17'd130000;
    localparam sqsum_t  TARGET_MS    = 24'd16;  // Target mean square of the codes
    localparam sqsum_t  MS_ERR       = 24'd0;
    localparam count_t  OFFSET_ERR   = 10'd5;   // Allowed gt/lt imbalance
    localparam int      BOOT_CYCLES  = 32;

    typedef enum logic [2:0] {
        BOOT,
        CLEAR,
        WAIT,
        CALC,
        APPLY
    } loop_state_t;

    // Snapshot of the last window and the gain in use
    typedef struct packed {
        logic    status;
        sqsum_t  sqsum;
        count_t  gt_count;
        count_t  lt_count;
        scale_t  scale;
        offset_t offset;
    } agc_info_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [7:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

endpackage

`default_nettype wire

// ==== agc_gain.sv ====
`timescale 1ns/1ps
`default_nettype none

module agc_gain (
    input  logic                                    aclk,
    input  logic                                    wb_rst_i,
    input  logic                                    apply_i,
    input  agc_pkg::scale_t                         scale_i,
    input  agc_pkg::offset_t                        offset_i,
    input  agc_pkg::sample_t [agc_pkg::NSAMP-1:0]   dat_i,
    output agc_pkg::code_t   [agc_pkg::NSAMP-1:0]   dat_o
);

    agc_pkg::scale_t  scale_q;                  // Gain in use
    agc_pkg::offset_t offset_q;

    logic signed [16:0] biased  [agc_pkg::NSAMP];
    logic signed [34:0] prod_q  [agc_pkg::NSAMP];
    logic signed [34:0] shifted [agc_pkg::NSAMP];

    // New values only reach samples sampled after the apply edge
    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            scale_q  <= agc_pkg::START_SCALE;
            offset_q <= agc_pkg::START_OFFSET;
        end else if (apply_i) begin
            scale_q  <= scale_i;
            offset_q <= offset_i;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stage 1: bias and multiply
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < agc_pkg::NSAMP; i++) begin
            biased[i] = dat_i[i] + offset_q;
        end
    end

    always_ff @(posedge aclk) begin
        for (int i = 0; i < agc_pkg::NSAMP; i++) begin
            prod_q[i] <= biased[i] * $signed({1'b0, scale_q});   // Scale is unsigned
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stage 2: drop fraction bits and clip to the code range
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < agc_pkg::NSAMP; i++) begin
            shifted[i] = prod_q[i] >>> agc_pkg::SCALE_FRAC_BITS;
        end
    end

    always_ff @(posedge aclk) begin
        for (int i = 0; i < agc_pkg::NSAMP; i++) begin
            if (wb_rst_i)
                dat_o[i] <= '0;
            else if (shifted[i] > agc_pkg::CODE_MAX)
                dat_o[i] <= agc_pkg::CODE_MAX;
            else if (shifted[i] < agc_pkg::CODE_MIN)
                dat_o[i] <= agc_pkg::CODE_MIN;
            else
                dat_o[i] <= shifted[i][4:0];
        end
    end

endmodule

`default_nettype wire

// ==== agc_stats.sv ====
`timescale 1ns/1ps
`default_nettype none

module agc_stats (
    input  logic                                    aclk,
    input  logic                                    wb_rst_i,
    input  logic                                    clear_i,
    input  agc_pkg::code_t [agc_pkg::NSAMP-1:0]     code_i,
    output logic                                    done_o,
    output agc_pkg::sqsum_t                         sqsum_o,
    output agc_pkg::count_t                         gt_o,
    output agc_pkg::count_t                         lt_o
);

    logic [agc_pkg::WINDOW_BITS-1:0] win_cnt;   // Clocks into the window

    logic signed [9:0] sq;
    logic [11:0]       lane_sq;                 // Four squares, at most 1024
    logic [2:0]        lane_gt;
    logic [2:0]        lane_lt;

    // Per-clock totals over the four lanes
    always_comb begin
        lane_sq = '0;
        lane_gt = '0;
        lane_lt = '0;
        sq      = '0;
        for (int i = 0; i < agc_pkg::NSAMP; i++) begin
            sq      = $signed(code_i[i]) * $signed(code_i[i]);
            lane_sq = lane_sq + 12'(sq);
            if (code_i[i][4])
                lane_lt = lane_lt + 3'd1;
            else if (|code_i[i])
                lane_gt = lane_gt + 3'd1;       // Zero counts as neither
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Window accumulation
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (wb_rst_i || clear_i) begin
            win_cnt <= '0;
            done_o  <= 1'b0;
            sqsum_o <= '0;
            gt_o    <= '0;
            lt_o    <= '0;
        end else if (!done_o) begin
            sqsum_o <= sqsum_o + agc_pkg::sqsum_t'(lane_sq);
            gt_o    <= gt_o + agc_pkg::count_t'(lane_gt);
            lt_o    <= lt_o + agc_pkg::count_t'(lane_lt);
            win_cnt <= win_cnt + 1'b1;
            if (&win_cnt)
                done_o <= 1'b1;                 // Results frozen until next clear
        end
    end

endmodule

`default_nettype wire

// ==== agc_loop_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module agc_loop_ctrl (
    input  logic                aclk,
    input  logic                wb_rst_i,
    input  logic                agc_reset_i,
    input  logic                stats_done_i,
    input  agc_pkg::sqsum_t     sqsum_i,
    input  agc_pkg::count_t     gt_i,
    input  agc_pkg::count_t     lt_i,
    output logic                stats_clear_o,
    output logic                apply_o,
    output agc_pkg::scale_t     scale_o,
    output agc_pkg::offset_t    offset_o,
    output agc_pkg::agc_info_t  info_o
);

    agc_pkg::loop_state_t state;
    logic [$clog2(agc_pkg::BOOT_CYCLES)-1:0] boot_cnt;

    agc_pkg::sqsum_t  mean_sq;
    agc_pkg::scale_t  scale_nxt;
    agc_pkg::offset_t offset_nxt;

    // 256 codes per window
    assign mean_sq = info_o.sqsum >> (agc_pkg::WINDOW_BITS + 2);

    //////////////////////////////////////////////////////////////////////
    // Step rules, fixed deltas
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        scale_nxt  = scale_o;
        offset_nxt = offset_o;
        if (mean_sq > agc_pkg::TARGET_MS + agc_pkg::MS_ERR) begin
            if (scale_o > agc_pkg::SCALE_FLOOR)
                scale_nxt = scale_o - agc_pkg::SCALE_DELTA;
        end else if (mean_sq < agc_pkg::TARGET_MS - agc_pkg::MS_ERR) begin
            if (scale_o < agc_pkg::SCALE_CEIL)
                scale_nxt = scale_o + agc_pkg::SCALE_DELTA;
        end
        // Pull the codes back towards zero mean
        if (info_o.gt_count > info_o.lt_count + agc_pkg::OFFSET_ERR)
            offset_nxt = offset_o - agc_pkg::OFFSET_DELTA;
        else if (info_o.lt_count > info_o.gt_count + agc_pkg::OFFSET_ERR)
            offset_nxt = offset_o + agc_pkg::OFFSET_DELTA;
    end

    //////////////////////////////////////////////////////////////////////
    // Loop FSM
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (wb_rst_i || agc_reset_i) begin
            state         <= agc_pkg::BOOT;
            boot_cnt      <= '0;
            scale_o       <= agc_pkg::START_SCALE;
            offset_o      <= agc_pkg::START_OFFSET;
            apply_o       <= ~wb_rst_i;         // Loop restart reloads the gain
            stats_clear_o <= ~wb_rst_i;
            info_o        <= '{status:   1'b0,
                              sqsum:    '0,
                              gt_count: '0,
                              lt_count: '0,
                              scale:    agc_pkg::START_SCALE,
                              offset:   agc_pkg::START_OFFSET};
        end else begin
            apply_o       <= 1'b0;
            stats_clear_o <= 1'b0;
            info_o.status <= stats_done_i;
            case (state)
                agc_pkg::BOOT: begin
                    if (boot_cnt == $bits(boot_cnt)'(agc_pkg::BOOT_CYCLES - 1)) begin
                        state   <= agc_pkg::APPLY;
                        apply_o <= 1'b1;        // Start values
                    end else begin
                        boot_cnt <= boot_cnt + 1'b1;
                    end
                end
                agc_pkg::CLEAR: state <= agc_pkg::WAIT;     // Clear pulse is out
                agc_pkg::WAIT: begin
                    if (stats_done_i) begin
                        info_o.sqsum    <= sqsum_i;
                        info_o.gt_count <= gt_i;
                        info_o.lt_count <= lt_i;
                        state           <= agc_pkg::CALC;
                    end
                end
                agc_pkg::CALC: begin
                    scale_o  <= scale_nxt;
                    offset_o <= offset_nxt;
                    apply_o  <= 1'b1;
                    state    <= agc_pkg::APPLY;
                end
                agc_pkg::APPLY: begin
                    info_o.scale  <= scale_o;   // Gain loads these this cycle
                    info_o.offset <= offset_o;
                    stats_clear_o <= 1'b1;
                    state         <= agc_pkg::CLEAR;
                end
                default: state <= agc_pkg::BOOT;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== agc_reg_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module agc_reg_port (
    input  logic                aclk,
    input  logic                wb_rst_i,
    input  agc_pkg::wb_req_t    wb_req_i,
    input  agc_pkg::agc_info_t  info_i,
    output logic                wb_ack_o,
    output logic [31:0]         wb_dat_o
);

    typedef enum logic [1:0] {
        IDLE,
        READ,
        ACK
    } port_state_t;

    port_state_t state;

    assign wb_ack_o = (state == ACK);

    always_ff @(posedge aclk) begin
        if (wb_rst_i)
            state <= IDLE;
        else begin
            case (state)
                IDLE:    if (wb_req_i.cyc && wb_req_i.stb) state <= READ;
                READ:    state <= ACK;          // Writes pass through here too
                ACK:     state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Snapshot word select, writes leave the data alone
    always_ff @(posedge aclk) begin
        if (state == READ && !wb_req_i.we) begin
            case (wb_req_i.adr[5:2])
                4'd0:    wb_dat_o <= {31'b0, info_i.status};
                4'd1:    wb_dat_o <= 32'(info_i.sqsum);
                4'd2:    wb_dat_o <= 32'(info_i.gt_count);
                4'd3:    wb_dat_o <= 32'(info_i.lt_count);
                4'd4:    wb_dat_o <= 32'(info_i.scale);
                4'd5:    wb_dat_o <= {{16{info_i.offset[15]}}, info_i.offset};
                default: wb_dat_o <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== agc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module agc_top (
    input  logic                                    aclk,
    input  logic                                    wb_rst_i,
    input  logic                                    agc_reset_i,
    input  agc_pkg::sample_t [agc_pkg::NSAMP-1:0]   dat_i,
    output agc_pkg::code_t   [agc_pkg::NSAMP-1:0]   dat_o,
    input  agc_pkg::wb_req_t                        wb_req_i,
    output logic                                    wb_ack_o,
    output logic [31:0]                             wb_dat_o
);

    logic               stats_clear;
    logic               stats_done;
    logic               apply;
    agc_pkg::sqsum_t    sqsum;
    agc_pkg::count_t    gt_count;
    agc_pkg::count_t    lt_count;
    agc_pkg::scale_t    scale;
    agc_pkg::offset_t   offset;
    agc_pkg::agc_info_t info;

    agc_gain u_gain (
        .aclk     (aclk),
        .wb_rst_i (wb_rst_i),
        .apply_i  (apply),
        .scale_i  (scale),
        .offset_i (offset),
        .dat_i    (dat_i),
        .dat_o    (dat_o)
    );

    // Statistics watch the output codes
    agc_stats u_stats (
        .aclk     (aclk),
        .wb_rst_i (wb_rst_i),
        .clear_i  (stats_clear),
        .code_i   (dat_o),
        .done_o   (stats_done),
        .sqsum_o  (sqsum),
        .gt_o     (gt_count),
        .lt_o     (lt_count)
    );

    agc_loop_ctrl u_loop_ctrl (
        .aclk          (aclk),
        .wb_rst_i      (wb_rst_i),
        .agc_reset_i   (agc_reset_i),
        .stats_done_i  (stats_done),
        .sqsum_i       (sqsum),
        .gt_i          (gt_count),
        .lt_i          (lt_count),
        .stats_clear_o (stats_clear),
        .apply_o       (apply),
        .scale_o       (scale),
        .offset_o      (offset),
        .info_o        (info)
    );

    agc_reg_port u_reg_port (
        .aclk     (aclk),
        .wb_rst_i (wb_rst_i),
        .wb_req_i (wb_req_i),
        .info_i   (info),
        .wb_ack_o (wb_ack_o),
        .wb_dat_o (wb_dat_o)
    );

endmodule

`default_nettype wire

// ==== agc_top_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module agc_top_sva (
    input  wire logic                                    aclk,
    input  wire logic                                    wb_rst_i,
    input  wire logic                                    agc_reset_i,
    input  wire agc_pkg::sample_t [agc_pkg::NSAMP-1:0]   dat_i,
    input  wire agc_pkg::code_t   [agc_pkg::NSAMP-1:0]   dat_o,
    input  wire agc_pkg::wb_req_t                        wb_req_i,
    input  wire logic                                    wb_ack_o
);

    typedef agc_pkg::code_t [agc_pkg::NSAMP-1:0] lanes_t;

    logic [4:0] boot_age;                       // Clocks since the loop restart
    int         sva_errs;

    // Expected codes for the start gain
    function automatic lanes_t start_gain(input agc_pkg::sample_t [agc_pkg::NSAMP-1:0] x);
        lanes_t res;
        int     v;
        for (int i = 0; i < agc_pkg::NSAMP; i++) begin
            v = (int'(x[i]) + int'(agc_pkg::START_OFFSET)) * int'(agc_pkg::START_SCALE);
            v = v >>> agc_pkg::SCALE_FRAC_BITS;
            if (v > 15)
                v = 15;
            else if (v < -16)
                v = -16;
            res[i] = agc_pkg::code_t'(v);
        end
        return res;
    endfunction

    always_ff @(posedge aclk) begin
        if (wb_rst_i)
            boot_age <= 5'd31;                  // Idle until a loop restart
        else if (agc_reset_i)
            boot_age <= '0;
        else if (boot_age != 5'd31)
            boot_age <= boot_age + 1'b1;
    end

    initial sva_errs = 0;

    boot_gain: assert property (@(posedge aclk) disable iff (wb_rst_i)
        (boot_age >= 5'd3 && boot_age <= 5'd30) |-> dat_o == start_gain($past(dat_i, 2)))
        else begin
            sva_errs++;
            $error("dat_o does not follow the start gain during BOOT");
        end

    ack_timing: assert property (@(posedge aclk) disable iff (wb_rst_i)
        (wb_req_i.cyc && wb_req_i.stb && !$past(wb_req_i.cyc))
            |-> !wb_ack_o ##1 !wb_ack_o ##1 wb_ack_o ##1 !wb_ack_o)
        else begin
            sva_errs++;
            $error("wb_ack_o not a single pulse two cycles after the request");
        end

    reset_state: assert property (@(posedge aclk)
        $past(wb_rst_i) |-> (dat_o == '0 && !wb_ack_o))
        else begin
            sva_errs++;
            $error("outputs not cleared by reset");
        end

endmodule

bind agc_top agc_top_sva u_sva (
    .aclk        (aclk),
    .wb_rst_i    (wb_rst_i),
    .agc_reset_i (agc_reset_i),
    .dat_i       (dat_i),
    .dat_o       (dat_o),
    .wb_req_i    (wb_req_i),
    .wb_ack_o    (wb_ack_o)
);

`default_nettype wire

// ==== tb_agc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_agc_top;

    localparam int CYCLE_LIMIT = 20000;         // Four phases plus margin

    logic                                    aclk;
    logic                                    wb_rst_i;
    logic                                    agc_reset_i;
    agc_pkg::sample_t [agc_pkg::NSAMP-1:0]   dat_i;
    agc_pkg::code_t   [agc_pkg::NSAMP-1:0]   dat_o;
    agc_pkg::wb_req_t                        wb_req_i;
    logic                                    wb_ack_o;
    logic [31:0]                             wb_dat_o;

    logic [31:0] lfsr;
    int          cycle_cnt;
    int          errors;
    int          checks;
    int          mag;                           // Sample magnitude
    logic        rand_sign;

    agc_top DUT (
        .aclk        (aclk),
        .wb_rst_i    (wb_rst_i),
        .agc_reset_i (agc_reset_i),
        .dat_i       (dat_i),
        .dat_o       (dat_o),
        .wb_req_i    (wb_req_i),
        .wb_ack_o    (wb_ack_o),
        .wb_dat_o    (wb_dat_o)
    );

    initial aclk = 1'b0;
    always #4 aclk = ~aclk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic take_bit();
        lfsr = lfsr_next(lfsr);
        return lfsr[0];
    endfunction

    always @(posedge aclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    // Two lanes of each sign per clock keep the code counts balanced
    // Without random signs every lane gets the same positive input
    always @(posedge aclk) begin
        logic b;
        logic s;
        int   m;
        s = rand_sign;
        m = mag;
        b = s ? take_bit() : 1'b0;
        #1;
        for (int i = 0; i < agc_pkg::NSAMP; i++)
            dat_i[i] <= agc_pkg::sample_t'((s && (b ^ i[0])) ? -m : m);
    end

    task automatic bus_read(input logic [7:0] adr, output logic [31:0] data);
        int gap;
        int wait_cnt;
        gap = 1 + int'({take_bit(), take_bit()});
        repeat (gap) @(posedge aclk);
        #1;
        wb_req_i = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: '0};
        wait_cnt = 0;
        do begin
            @(posedge aclk);
            #1;
            wait_cnt++;
        end while (!wb_ack_o && wait_cnt < 16);
        if (!wb_ack_o) begin
            $display("Bus read at address %h got no acknowledge", adr);
            errors++;
        end
        data     = wb_dat_o;
        wb_req_i = '0;
    endtask

    task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            $display("ERR %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic restart_loop();
        @(posedge aclk);
        #1 agc_reset_i = 1'b1;
        @(posedge aclk);
        #1 agc_reset_i = 1'b0;
    endtask

    task automatic check_start_values();
        logic [31:0] d;
        bus_read(8'h10, d);
        check_equal("scale", d, 32'(agc_pkg::START_SCALE));
        bus_read(8'h14, d);
        check_equal("offset", d, 32'(signed'(agc_pkg::START_OFFSET)));
    endtask

    // Reads one register for a number of cycles; dir -1 no rise, +1 no fall
    task automatic track_reg(input string name, input logic [7:0] adr, input int dir,
                             input int cycles, output int last);
        logic [31:0] d;
        int          prev;
        int          start;
        start = cycle_cnt;
        bus_read(adr, d);
        prev = int'(d);
        while (cycle_cnt - start < cycles) begin
            bus_read(adr, d);
            checks++;
            assert ((dir < 0) ? (int'(d) <= prev) : (int'(d) >= prev)) else begin
                $display("ERR %s: got %h, previous %h", name, d, prev);
                errors++;
            end
            if (name == "scale")
                check_equal("scale step", 32'((prev - int'(d)) % 30), 32'h0);
            prev = int'(d);
        end
        last = prev;
    endtask

    initial begin
        int last;
        lfsr        = 32'h6a58;
        cycle_cnt   = 0;
        errors      = 0;
        checks      = 0;
        mag         = 2000;
        rand_sign   = 1'b1;
        wb_rst_i    = 1'b1;
        agc_reset_i = 1'b0;
        wb_req_i    = '0;
        dat_i       = '0;
        repeat (2) @(posedge aclk);
        #1 wb_rst_i = 1'b0;

        check_start_values();
        // Large input drives the scale down to the floor
        track_reg("scale", 8'h10, -1, 3200, last);
        checks++;
        assert (last <= 330 && last >= 270) else begin
            $display("ERR scale: got %h, expected near %h", last, agc_pkg::SCALE_FLOOR);
            errors++;
        end

        mag = 8;                                // Small input raises the scale
        restart_loop();
        check_start_values();
        track_reg("scale", 8'h10, 1, 1000, last);

        mag       = 40;
        rand_sign = 1'b0;
        restart_loop();
        track_reg("offset", 8'h14, -1, 220, last);
        checks++;
        assert (last < int'(agc_pkg::START_OFFSET)) else begin
            $display("ERR offset: got %h, expected below %h", last, agc_pkg::START_OFFSET);
            errors++;
        end

        $display("Checks: %0d, errors: %0d, assertion errors: %0d",
                 checks, errors, DUT.u_sva.sva_errs);
        if (errors == 0 && DUT.u_sva.sva_errs == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
agc_pkg.sv
agc_gain.sv
agc_stats.sv
agc_loop_ctrl.sv
agc_reg_port.sv
agc_top.sv
agc_top_sva.sv
tb_agc_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_agc_top
FILELIST  ?= filelist.f
OBJDIR    ?= obj_dir
PASS_MSG  := Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
